// ==== Makefile ====
SIM = obj_dir/loopFilterSim
LOG = sim.log

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): compile.f hdl/*.sv tests/*.sv
	verilator --binary --timing --assert -j 0 --top-module loopFilterTb \
		-f compile.f -o loopFilterSim

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "CHECKS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qx "ALL CHECKS PASSED" $(LOG); then echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== compile.f ====
hdl/loopFilterPkg.sv
hdl/loopRegs.sv
hdl/loopGain.sv
hdl/lagIntegrator.sv
hdl/loopSum.sv
hdl/loopFilter.sv
tests/loopFilter_asserts.sv
tests/loopFilterTb.sv

// ==== hdl/lagIntegrator.sv ====
`timescale 1ns/1ns
`default_nettype none

module lagIntegrator import loopFilterPkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic clear,
    input  wire termT lagTerm,
    input  wire logic lagValid,
    output termT      integ,
    output logic      integValid
);

    termT nextInteg;

    // saturating accumulate.
    assign nextInteg = satAdd(integ, lagTerm);

    always_ff @(posedge clk) begin
        if (reset) begin
            integ      <= '0;
            integValid <= 1'b0;
        end else begin
            integValid <= lagValid;
            // clear wins over a sample arriving in the same cycle.
            if (clear) begin
                integ <= '0;
            end else if (lagValid) begin
                integ <= nextInteg;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/loopFilter.sv ====
`timescale 1ns/1ns
`default_nettype none

module loopFilter import loopFilterPkg::*; (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire apbReqT apbReq,
    input  wire errorT  error,
    input  wire logic   errorValid,
    output apbDataT     prdata,
    output logic        pready,
    output logic        pslverr,
    output termT        filterOut,
    output logic        outValid
);

    loopCfgT cfg;
    logic    clearIntegrator;
    logic    sampleEn;
    termT    leadTerm;
    termT    lagTerm;
    logic    lagValid;
    termT    integ;
    logic    integValid;

    loopRegs regs (
        .clk             (clk),
        .reset           (reset),
        .apbReq          (apbReq),
        .errorValid      (errorValid),
        .integ           (integ),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .cfg             (cfg),
        .clearIntegrator (clearIntegrator),
        .sampleEn        (sampleEn)
    );

    // lead timing follows the lag strobe, its own valid is not needed.
    loopGain leadGain (
        .clk       (clk),
        .reset     (reset),
        .clkEn     (sampleEn),
        .error     (error),
        .gainExp   (cfg.leadExp),
        .term      (leadTerm),
        .termValid ()
    );

    loopGain lagGain (
        .clk       (clk),
        .reset     (reset),
        .clkEn     (sampleEn),
        .error     (error),
        .gainExp   (cfg.lagExp),
        .term      (lagTerm),
        .termValid (lagValid)
    );

    lagIntegrator integrator (
        .clk        (clk),
        .reset      (reset),
        .clear      (clearIntegrator),
        .lagTerm    (lagTerm),
        .lagValid   (lagValid),
        .integ      (integ),
        .integValid (integValid)
    );

    loopSum sum (
        .clk        (clk),
        .reset      (reset),
        .leadTerm   (leadTerm),
        .integ      (integ),
        .integValid (integValid),
        .filterOut  (filterOut),
        .outValid   (outValid)
    );

endmodule

`default_nettype wire

// ==== hdl/loopFilterPkg.sv ====
`default_nettype none

package loopFilterPkg;

    localparam int ERROR_W    = 8;
    localparam int EXP_W      = 5;
    localparam int TERM_W     = 32;
    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    typedef logic signed [ERROR_W-1:0] errorT;
    typedef logic [EXP_W-1:0]          expT;
    typedef logic signed [TERM_W-1:0]  termT;
    typedef logic [APB_ADDR_W-1:0]     apbAddrT;
    typedef logic [APB_DATA_W-1:0]     apbDataT;

    typedef struct packed {
        logic    sel;
        logic    enable;
        logic    write;
        apbAddrT addr;
        apbDataT wdata;
    } apbReqT;

    typedef struct packed {
        logic enable;
        expT  leadExp;
        expT  lagExp;
    } loopCfgT;

    // register map.
    localparam apbAddrT CTRL_ADDR  = 8'h00;
    localparam apbAddrT LEAD_ADDR  = 8'h04;
    localparam apbAddrT LAG_ADDR   = 8'h08;
    localparam apbAddrT INTEG_ADDR = 8'h0C;

    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_CLEAR_BIT  = 1;

    localparam termT TERM_MAX = 32'sh7FFF_FFFF;
    localparam termT TERM_MIN = 32'sh8000_0000;

    // signed add clamped to the term range.
    function automatic termT satAdd(input termT a, input termT b);
        logic [TERM_W:0] wide;
        wide = {a[TERM_W-1], a} + {b[TERM_W-1], b};
        // the two top bits disagree only on overflow.
        if (wide[TERM_W] != wide[TERM_W-1]) begin
            return wide[TERM_W] ? TERM_MIN : TERM_MAX;
        end
        return termT'(wide[TERM_W-1:0]);
    endfunction

endpackage

`default_nettype wire

// ==== hdl/loopGain.sv ====
`timescale 1ns/1ns
`default_nettype none

module loopGain import loopFilterPkg::*; (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  clkEn,
    input  wire errorT error,
    input  wire expT   gainExp,
    output termT       term,
    output logic       termValid
);

    // an exponent of 7 passes the error through unscaled.
    localparam expT UNITY_EXP = expT'(ERROR_W - 1);

    termT extError;
    termT scaled;
    termT fillMask;
    expT  rightShift;
    expT  leftShift;

    assign extError   = termT'(error);
    assign rightShift = UNITY_EXP - gainExp;
    assign leftShift  = gainExp - UNITY_EXP;

    // vacated low bits take the sign, so negative errors get ones below.
    assign fillMask = error[ERROR_W-1] ? ~({TERM_W{1'b1}} << leftShift) : '0;

    always_comb begin
        if (gainExp == '0) begin
            scaled = '0;
        end else if (gainExp <= UNITY_EXP) begin
            scaled = extError >>> rightShift;
        end else begin
            scaled = (extError <<< leftShift) | fillMask;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            term      <= '0;
            termValid <= 1'b0;
        end else begin
            termValid <= clkEn;
            if (clkEn) begin
                term <= scaled;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/loopRegs.sv ====
`timescale 1ns/1ns
`default_nettype none

module loopRegs import loopFilterPkg::*; (
    input  wire logic    clk,
    input  wire logic    reset,
    input  wire apbReqT  apbReq,
    input  wire logic    errorValid,
    input  wire termT    integ,
    output apbDataT      prdata,
    output logic         pready,
    output logic         pslverr,
    output loopCfgT      cfg,
    output logic         clearIntegrator,
    output logic         sampleEn
);

    logic access;
    logic mapped;
    logic writeOk;

    // access phase of a transfer.
    assign access = apbReq.sel & apbReq.enable;

    always_comb begin
        case (apbReq.addr)
            CTRL_ADDR, LEAD_ADDR, LAG_ADDR, INTEG_ADDR: mapped = 1'b1;
            default:                                    mapped = 1'b0;
        endcase
    end

    // integrator readback is not writable.
    assign pslverr = access & (~mapped | (apbReq.write & (apbReq.addr == INTEG_ADDR)));
    assign writeOk = access & apbReq.write & ~pslverr;

    // no wait states.
    assign pready = 1'b1;

    always_comb begin
        case (apbReq.addr)
            CTRL_ADDR:  prdata = apbDataT'(cfg.enable);
            LEAD_ADDR:  prdata = apbDataT'(cfg.leadExp);
            LAG_ADDR:   prdata = apbDataT'(cfg.lagExp);
            INTEG_ADDR: prdata = apbDataT'(integ);
            default:    prdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg             <= '0;
            clearIntegrator <= 1'b0;
        end else begin
            // clear is a pulse, it drops on its own.
            clearIntegrator <= writeOk & (apbReq.addr == CTRL_ADDR)
                             & apbReq.wdata[CTRL_CLEAR_BIT];
            if (writeOk) begin
                case (apbReq.addr)
                    CTRL_ADDR: begin
                        cfg.enable <= apbReq.wdata[CTRL_ENABLE_BIT];
                    end
                    LEAD_ADDR: begin
                        cfg.leadExp <= apbReq.wdata[EXP_W-1:0];
                    end
                    LAG_ADDR: begin
                        cfg.lagExp <= apbReq.wdata[EXP_W-1:0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // samples are ignored while the loop is disabled.
    assign sampleEn = errorValid & cfg.enable;

endmodule

`default_nettype wire

// ==== hdl/loopSum.sv ====
`timescale 1ns/1ns
`default_nettype none

module loopSum import loopFilterPkg::*; (
    input  wire logic clk,
    input  wire logic reset,
    input  wire termT leadTerm,
    input  wire termT integ,
    input  wire logic integValid,
    output termT      filterOut,
    output logic      outValid
);

    termT leadDelay;

    // one stage so the lead term meets the integrator of the same sample.
    always_ff @(posedge clk) begin
        leadDelay <= leadTerm;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            filterOut <= '0;
            outValid  <= 1'b0;
        end else begin
            outValid <= integValid;
            if (integValid) begin
                filterOut <= satAdd(leadDelay, integ);
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/loopFilterTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module loopFilterTb import loopFilterPkg::*; ();

    localparam int WAIT_LIMIT = 200;

    logic    clk;
    logic    reset;
    apbReqT  apbReq;
    errorT   error;
    logic    errorValid;
    apbDataT prdata;
    logic    pready;
    logic    pslverr;
    termT    filterOut;
    logic    outValid;

    int   errorCount;
    int   checkCount;
    int   seed;
    termT expectQ[$];
    termT expectedOut;

    // shadow copy of the register state and the accumulator.
    logic shadowEnable;
    expT  shadowLead;
    expT  shadowLag;
    termT shadowAcc;

    loopFilter uut (
        .clk        (clk),
        .reset      (reset),
        .apbReq     (apbReq),
        .error      (error),
        .errorValid (errorValid),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .filterOut  (filterOut),
        .outValid   (outValid)
    );

    always #5 clk = ~clk;

    task automatic compareTerm(input termT got, input termT exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("** Error at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compareData(input apbDataT got, input apbDataT exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compareFlag(input logic got, input logic exp, input string what);
        checkCount++;
        if (got !== exp) begin
            errorCount++;
            $display("** Error at %0t ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic abortRun(input string reason);
        $display("%s at %0t ns", reason, $time);
        $display("checks %0d, errors %0d", checkCount, errorCount + 1);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // power-of-two gain that fills vacated low bits with the sign.
    function automatic termT scaleError(input errorT e, input expT x);
        longint v;
        int     k;
        v = longint'(e);
        k = int'(x) - 7;
        if (x == 5'd0) begin
            v = 0;
        end else if (k <= 0) begin
            v = v >>> (-k);
        end else begin
            v = v * (longint'(1) << k);
            if (e < 0) begin
                v = v + ((longint'(1) << k) - 1);
            end
        end
        return termT'(v);
    endfunction

    function automatic termT clampTerm(input longint v);
        if (v > longint'(TERM_MAX)) begin
            return TERM_MAX;
        end
        if (v < longint'(TERM_MIN)) begin
            return TERM_MIN;
        end
        return termT'(v);
    endfunction

    task automatic modelSample(input errorT e);
        termT lead;
        lead = scaleError(e, shadowLead);
        shadowAcc = clampTerm(longint'(shadowAcc) + longint'(scaleError(e, shadowLag)));
        expectQ.push_back(clampTerm(longint'(lead) + longint'(shadowAcc)));
    endtask

    // outputs are sampled in the middle of the cycle.
    always @(negedge clk) begin
        if (!reset && outValid) begin
            if (expectQ.size() == 0) begin
                errorCount++;
                $display("unexpected filter output at %0t ns", $time);
            end else begin
                expectedOut = expectQ.pop_front();
                compareTerm(filterOut, expectedOut, "filterOut");
            end
        end
    end

    task automatic waitAccess();
        int waitCount;
        waitCount = 0;
        @(negedge clk);
        while (!pready && waitCount < WAIT_LIMIT) begin
            @(negedge clk);
            waitCount++;
        end
        if (!pready) begin
            abortRun("APB transfer never completed");
        end
    endtask

    task automatic apbWrite(input apbAddrT addr, input apbDataT data, input logic expErr);
        @(posedge clk);
        #1;
        apbReq.sel    = 1'b1;
        apbReq.enable = 1'b0;
        apbReq.write  = 1'b1;
        apbReq.addr   = addr;
        apbReq.wdata  = data;
        @(posedge clk);
        #1;
        apbReq.enable = 1'b1;
        waitAccess();
        compareFlag(pslverr, expErr, "pslverr on write");
        @(posedge clk);
        #1;
        apbReq = '0;
        if (!expErr) begin
            case (addr)
                CTRL_ADDR: begin
                    shadowEnable = data[0];
                    if (data[1]) begin
                        shadowAcc = '0;
                    end
                end
                LEAD_ADDR: shadowLead = data[EXP_W-1:0];
                LAG_ADDR:  shadowLag = data[EXP_W-1:0];
                default: begin
                end
            endcase
        end
    endtask

    task automatic apbRead(input apbAddrT addr, input apbDataT expData, input logic expErr);
        @(posedge clk);
        #1;
        apbReq.sel    = 1'b1;
        apbReq.enable = 1'b0;
        apbReq.write  = 1'b0;
        apbReq.addr   = addr;
        apbReq.wdata  = '0;
        @(posedge clk);
        #1;
        apbReq.enable = 1'b1;
        waitAccess();
        compareFlag(pslverr, expErr, "pslverr on read");
        if (!expErr) begin
            compareData(prdata, expData, "prdata");
        end
        @(posedge clk);
        #1;
        apbReq = '0;
    endtask

    task automatic driveSample(input errorT e);
        @(posedge clk);
        #1;
        error      = e;
        errorValid = 1'b1;
        if (shadowEnable) begin
            modelSample(e);
        end
    endtask

    task automatic idleInput();
        @(posedge clk);
        #1;
        errorValid = 1'b0;
        error      = '0;
    endtask

    task automatic waitOutputs();
        int waitCount;
        waitCount = 0;
        while (expectQ.size() > 0 && waitCount < WAIT_LIMIT) begin
            @(negedge clk);
            waitCount++;
        end
        if (expectQ.size() > 0) begin
            abortRun("output valid never arrived");
        end
    endtask

    task automatic sendRandom(input int count);
        errorT sample;
        for (int i = 0; i < count; i++) begin
            sample = errorT'($random(seed));
            driveSample(sample);
        end
        idleInput();
        waitOutputs();
    endtask

    task automatic checkResetState();
        apbRead(CTRL_ADDR, '0, 1'b0);
        apbRead(LEAD_ADDR, '0, 1'b0);
        apbRead(LAG_ADDR, '0, 1'b0);
        apbRead(INTEG_ADDR, '0, 1'b0);
        // nothing may come out while the loop is disabled.
        for (int i = 0; i < 5; i++) begin
            driveSample(errorT'(8'h40 + i));
        end
        idleInput();
        repeat (6) begin
            @(negedge clk);
            compareFlag(outValid, 1'b0, "outValid while disabled");
        end
    endtask

    task automatic exerciseRegisters();
        apbWrite(CTRL_ADDR, 32'h1, 1'b0);
        apbRead(CTRL_ADDR, 32'h1, 1'b0);
        apbWrite(LEAD_ADDR, 32'h15, 1'b0);
        apbRead(LEAD_ADDR, apbDataT'(shadowLead), 1'b0);
        apbWrite(LAG_ADDR, 32'hFFFF_FFE6, 1'b0);
        apbRead(LAG_ADDR, apbDataT'(shadowLag), 1'b0);
        apbRead(8'h10, '0, 1'b1);
        apbWrite(8'h14, 32'h1, 1'b1);
        apbWrite(INTEG_ADDR, 32'h55, 1'b1);
        apbRead(INTEG_ADDR, apbDataT'(shadowAcc), 1'b0);
        apbRead(LEAD_ADDR, apbDataT'(shadowLead), 1'b0);
    endtask

    task automatic sweepLeadPath();
        expT   expList[5];
        errorT errList[6];
        expList = '{5'd0, 5'd1, 5'd7, 5'd8, 5'd31};
        errList = '{8'h05, 8'hFB, 8'h7F, 8'h80, 8'hFF, 8'h01};
        apbWrite(LAG_ADDR, 32'h0, 1'b0);
        apbWrite(CTRL_ADDR, 32'h3, 1'b0);
        foreach (expList[i]) begin
            apbWrite(LEAD_ADDR, apbDataT'(expList[i]), 1'b0);
            foreach (errList[j]) begin
                driveSample(errList[j]);
            end
            idleInput();
            waitOutputs();
        end
    endtask

    task automatic integrateRandom();
        apbWrite(LEAD_ADDR, 32'h0, 1'b0);
        apbWrite(LAG_ADDR, 32'd10, 1'b0);
        apbWrite(CTRL_ADDR, 32'h3, 1'b0);
        for (int s = 0; s < 3; s++) begin
            sendRandom(20);
            apbRead(INTEG_ADDR, apbDataT'(shadowAcc), 1'b0);
        end
    endtask

    task automatic driveSaturation();
        apbWrite(LEAD_ADDR, 32'd31, 1'b0);
        apbWrite(LAG_ADDR, 32'd31, 1'b0);
        repeat (6) driveSample(8'h7F);
        idleInput();
        waitOutputs();
        apbRead(INTEG_ADDR, apbDataT'(TERM_MAX), 1'b0);
        repeat (6) driveSample(8'h80);
        idleInput();
        waitOutputs();
        apbRead(INTEG_ADDR, apbDataT'(TERM_MIN), 1'b0);
        apbWrite(LEAD_ADDR, 32'd20, 1'b0);
        apbWrite(LAG_ADDR, 32'd24, 1'b0);
        sendRandom(30);
        apbRead(INTEG_ADDR, apbDataT'(shadowAcc), 1'b0);
    endtask

    task automatic clearAndRestart();
        apbWrite(CTRL_ADDR, 32'h3, 1'b0);
        apbRead(INTEG_ADDR, '0, 1'b0);
        apbWrite(LEAD_ADDR, 32'd7, 1'b0);
        apbWrite(LAG_ADDR, 32'd7, 1'b0);
        driveSample(8'h10);
        driveSample(8'hF0);
        driveSample(8'h22);
        idleInput();
        waitOutputs();
        apbRead(INTEG_ADDR, apbDataT'(shadowAcc), 1'b0);
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        apbReq       = '0;
        error        = '0;
        errorValid   = 1'b0;
        errorCount   = 0;
        checkCount   = 0;
        seed         = 78233;
        shadowEnable = 1'b0;
        shadowLead   = '0;
        shadowLag    = '0;
        shadowAcc    = '0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        checkResetState();
        exerciseRegisters();
        sweepLeadPath();
        integrateRandom();
        driveSaturation();
        clearAndRestart();

        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/loopFilter_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module loopFilterAsserts import loopFilterPkg::*; (
    input wire logic   clk,
    input wire logic   reset,
    input wire apbReqT apbReq,
    input wire logic   pready,
    input wire logic   errorValid,
    input wire logic   cfgEnable,
    input wire logic   outValid
);

    // no wait states in any access cycle.
    apbReady: assert property (@(posedge clk) disable iff (reset)
        (apbReq.sel && apbReq.enable) |-> pready)
        else $error("pready low in an APB access cycle");

    // pipeline latency is three cycles.
    validLatency: assert property (@(posedge clk) disable iff (reset)
        (errorValid && cfgEnable) |-> ##3 outValid)
        else $error("outValid missing three cycles after an accepted sample");

    validSource: assert property (@(posedge clk) disable iff (reset)
        outValid |-> $past(errorValid && cfgEnable, 3))
        else $error("outValid without an accepted sample three cycles before");

    quietInReset: assert property (@(posedge clk)
        (reset && $past(reset)) |-> !outValid)
        else $error("outValid high during reset");

endmodule

bind loopFilter loopFilterAsserts asserts (
    .clk        (clk),
    .reset      (reset),
    .apbReq     (apbReq),
    .pready     (pready),
    .errorValid (errorValid),
    .cfgEnable  (cfg.enable),
    .outValid   (outValid)
);

`default_nettype wire
